// ==== rob_unit.f ====
logic/rob_pkg.sv
logic/rob_alloc.sv
logic/rob_buffer.sv
logic/rob_commit.sv
logic/rob_unit.sv
sim/rob_unit_assert.sv
sim/rob_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f rob_unit.f --top-module rob_unit_tb -o rob_unit_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/rob_unit_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== sim/rob_unit_tb.sv ====
// --------------------
// Reorder buffer testbench
// Random completions and back-pressure against an in-order model
// --------------------

`timescale 1ns/100ps

module rob_unit_tb;

  import rob_pkg::*;

  // Per-cycle completion and ready modes
  localparam int cmpl_none  = -1;
  localparam int cmpl_rand  = -2;
  localparam int ready_low  = 0;
  localparam int ready_high = 1;
  localparam int ready_rand = 2;

  localparam int stress_count = 200;
  // Eight cycles per entry over all tests
  localparam int cycle_limit = 8 * (4 * rob_depth + 3 * stress_count) + 200;

  logic              clk;
  logic              rst_n;
  logic              dispatch_valid;
  logic [reg_w-1:0]  dispatch_dest;
  logic              dispatch_ready;
  logic [tag_w-1:0]  dispatch_tag;
  logic              cmpl_valid;
  logic [tag_w-1:0]  cmpl_tag;
  logic [data_w-1:0] cmpl_data;
  logic              commit_ready;
  logic              commit_valid;
  logic [tag_w-1:0]  commit_tag;
  logic [reg_w-1:0]  commit_dest;
  logic [data_w-1:0] commit_data;

  // Model of outstanding entries with the oldest first
  logic [tag_w-1:0]  q_tag[$];
  logic [reg_w-1:0]  q_dest[$];
  logic              q_done[$];
  logic [data_w-1:0] q_data[$];

  logic [31:0] rng;
  int next_dispatch_tag;
  int next_commit_tag;
  int dispatch_left;
  bit dispatch_taken;
  int committed;
  int checks;
  int errors;
  int tests;
  int test_errors;
  int cycle_count;

  rob_unit uut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("Error: %s", what);
      errors++;
    end
  endtask

  // Completion takes effect at the coming edge
  task automatic complete_entry(input int idx);
    rng = xorshift(rng);
    cmpl_valid  = 1'b1;
    cmpl_tag    = q_tag[idx];
    cmpl_data   = rng;
    q_done[idx] = 1'b1;
    q_data[idx] = rng;
  endtask

  // Any allocated entry still waiting for its result
  task automatic complete_random();
    int open;
    int pick;
    open = 0;
    foreach (q_done[i]) begin
      if (!q_done[i]) begin
        open++;
      end
    end
    if (open > 0) begin
      rng  = xorshift(rng);
      pick = int'(rng % 32'(open));
      foreach (q_done[i]) begin
        if (!q_done[i]) begin
          if (pick == 0) begin
            complete_entry(i);
          end
          pick--;
        end
      end
    end
  endtask

  // Handshakes seen here happen at the next rising edge
  task automatic observe();
    // Model count bounds buffer occupancy from above
    if (q_tag.size() < rob_depth) begin
      check_true(dispatch_ready, "dispatch_ready low while the buffer has a free entry");
    end
    dispatch_taken = 1'b0;
    if (dispatch_valid && dispatch_ready) begin
      check_value("dispatch_tag", 32'(dispatch_tag), next_dispatch_tag);
      q_tag.push_back(dispatch_tag);
      q_dest.push_back(dispatch_dest);
      q_done.push_back(1'b0);
      q_data.push_back('0);
      next_dispatch_tag = (next_dispatch_tag + 1) % rob_depth;
      dispatch_left--;
      dispatch_taken = 1'b1;
    end
    if (commit_valid && commit_ready) begin
      if (q_tag.size() == 0) begin
        check_true(1'b0, "commit seen with no outstanding entry");
      end else begin
        check_value("commit_tag", 32'(commit_tag), next_commit_tag);
        check_true(q_done[0], "entry committed before its result came back");
        check_value("commit_dest", 32'(commit_dest), 32'(q_dest[0]));
        check_value("commit_data", commit_data, q_data[0]);
        void'(q_tag.pop_front());
        void'(q_dest.pop_front());
        void'(q_done.pop_front());
        void'(q_data.pop_front());
        next_commit_tag = (next_commit_tag + 1) % rob_depth;
        committed++;
      end
    end
  endtask

  // Drive just after the edge and sample at the falling edge
  task automatic run_cycle(input int cmpl_mode, input int ready_mode);
    @(posedge clk);
    #1;
    // Destination only changes once the last one was taken
    if (dispatch_taken) begin
      rng = xorshift(rng);
      dispatch_dest = rng[reg_w-1:0];
    end
    dispatch_valid = (dispatch_left > 0);
    cmpl_valid = 1'b0;
    if (cmpl_mode >= 0) begin
      complete_entry(cmpl_mode);
    end else if (cmpl_mode == cmpl_rand) begin
      rng = xorshift(rng);
      if (rng[3]) begin
        complete_random();
      end
    end
    case (ready_mode)
      ready_low:  commit_ready = 1'b0;
      ready_high: commit_ready = 1'b1;
      default: begin
        rng = xorshift(rng);
        commit_ready = rng[7] | rng[9];
      end
    endcase
    @(negedge clk);
    observe();
  endtask

  task automatic drain(input int ready_mode);
    while (q_tag.size() > 0 || dispatch_left > 0) begin
      run_cycle(cmpl_rand, ready_mode);
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %0d %s finished with %0d errors", tests, name, errors - test_errors);
    test_errors = errors;
  endtask

  // --------------------
  // Timeout
  // --------------------

  initial begin
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // --------------------
  // Tests
  // --------------------

  initial begin
    rng = 32'he49d3d91;
    rst_n = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_dest = '0;
    cmpl_valid = 1'b0;
    cmpl_tag = '0;
    cmpl_data = '0;
    commit_ready = 1'b1;
    next_dispatch_tag = 0;
    next_commit_tag = 0;
    dispatch_left = 0;
    dispatch_taken = 1'b1;
    committed = 0;
    checks = 0;
    errors = 0;
    tests = 0;
    test_errors = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);

    // Fill every entry with nothing completed
    check_value("commit_valid", 32'(commit_valid), 32'h0);
    check_value("dispatch_ready", 32'(dispatch_ready), 32'h1);
    dispatch_left = rob_depth;
    while (dispatch_left > 0) begin
      run_cycle(cmpl_none, ready_high);
    end
    run_cycle(cmpl_none, ready_high);
    check_value("dispatch_ready", 32'(dispatch_ready), 32'h0);
    finish_test("fill");

    // Youngest first and head last
    for (int i = rob_depth - 1; i >= 0; i--) begin
      run_cycle(i, ready_high);
    end
    drain(ready_high);
    finish_test("reverse completion");

    // Stalled commit port fills skid stage and buffer
    dispatch_left = rob_depth + 4;
    repeat (3 * rob_depth) begin
      run_cycle(cmpl_rand, ready_low);
    end
    drain(ready_high);
    finish_test("back-pressure");

    // Head completion to commit_valid on an empty pipeline
    for (int n = 0; n < 3; n++) begin
      dispatch_left = 1;
      while (dispatch_left > 0) begin
        run_cycle(cmpl_none, ready_high);
      end
      run_cycle(0, ready_high);
      run_cycle(cmpl_none, ready_high);
      check_value("commit_valid", 32'(commit_valid), 32'h0);
      run_cycle(cmpl_none, ready_high);
      check_value("commit_valid", 32'(commit_valid), 32'h1);
    end
    finish_test("commit latency");

    // Continuous dispatch, random results and stalls
    dispatch_left = stress_count;
    drain(ready_rand);
    // Nothing left to commit once the model is empty
    run_cycle(cmpl_none, ready_high);
    check_value("commit_valid", 32'(commit_valid), 32'h0);
    finish_test("random stress");

    $display("Summary: %0d tests, %0d checks, %0d commits, %0d errors, %0d assertion failures",
             tests, checks, committed, errors, uut.chk.fail_count);
    if (errors == 0 && uut.chk.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim/rob_unit_assert.sv ====
// --------------------
// Reorder buffer protocol checks
// Stall stability, reset values and head commit latency
// --------------------

`timescale 1ns/100ps

module rob_unit_assert (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       dispatch_ready,
  input logic [rob_pkg::tag_w-1:0]  dispatch_tag,
  input logic                       cmpl_valid,
  input logic [rob_pkg::tag_w-1:0]  cmpl_tag,
  input logic                       retire_valid,
  input logic                       retire_ready,
  input logic [rob_pkg::tag_w-1:0]  retire_tag,
  input logic                       commit_valid,
  input logic                       commit_ready,
  input logic [rob_pkg::tag_w-1:0]  commit_tag,
  input logic [rob_pkg::reg_w-1:0]  commit_dest,
  input logic [rob_pkg::data_w-1:0] commit_data
);

  // Count of failed assertions
  int fail_count = 0;

  // --------------------
  // Reset values
  // --------------------

  a_reset_values: assert property (@(posedge clk)
    !rst_n |=> !commit_valid && !retire_valid && retire_ready &&
               dispatch_ready && (dispatch_tag == '0))
  else begin
    $error("Outputs not at their reset values during reset");
    fail_count++;
  end

  // --------------------
  // Back-pressure
  // --------------------

  // Commit port frozen while stalled
  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    commit_valid && !commit_ready |=> commit_valid && $stable(commit_tag) &&
                                      $stable(commit_dest) && $stable(commit_data))
  else begin
    $error("Commit outputs changed while commit_ready was low");
    fail_count++;
  end

  // Head waits in place when the skid stage is full
  a_head_waits: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire_tag))
  else begin
    $error("Head entry moved without a retire handshake");
    fail_count++;
  end

  // --------------------
  // Latency
  // --------------------

  // Undone head completing into an empty skid stage commits two edges later
  a_head_latency: assert property (@(posedge clk) disable iff (!rst_n)
    cmpl_valid && (cmpl_tag == retire_tag) && !retire_valid && !commit_valid
      |=> !commit_valid ##1 commit_valid)
  else begin
    $error("Head completion did not reach the commit port two cycles later");
    fail_count++;
  end

endmodule

bind rob_unit rob_unit_assert chk (
  .clk            (clk),
  .rst_n          (rst_n),
  .dispatch_ready (dispatch_ready),
  .dispatch_tag   (dispatch_tag),
  .cmpl_valid     (cmpl_valid),
  .cmpl_tag       (cmpl_tag),
  .retire_valid   (retire_valid),
  .retire_ready   (retire_ready),
  .retire_tag     (retire_tag),
  .commit_valid   (commit_valid),
  .commit_ready   (commit_ready),
  .commit_tag     (commit_tag),
  .commit_dest    (commit_dest),
  .commit_data    (commit_data)
);

// ==== logic/rob_unit.sv ====
// --------------------
// Reorder buffer top level
// Allocator, entry buffer and commit skid stage
// --------------------

`timescale 1ns/100ps

module rob_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  // Dispatch in program order
  input  logic                       dispatch_valid,
  input  logic [rob_pkg::reg_w-1:0]  dispatch_dest,
  output logic                       dispatch_ready,
  output logic [rob_pkg::tag_w-1:0]  dispatch_tag,
  // Tagged results, any order
  input  logic                       cmpl_valid,
  input  logic [rob_pkg::tag_w-1:0]  cmpl_tag,
  input  logic [rob_pkg::data_w-1:0] cmpl_data,
  // In-order commit port
  input  logic                       commit_ready,
  output logic                       commit_valid,
  output logic [rob_pkg::tag_w-1:0]  commit_tag,
  output logic [rob_pkg::reg_w-1:0]  commit_dest,
  output logic [rob_pkg::data_w-1:0] commit_data
);

  import rob_pkg::*;

  // --------------------
  // Internal wires
  // --------------------

  // Allocator to buffer
  logic              alloc_fire;
  logic [tag_w-1:0]  alloc_tag;
  logic [reg_w-1:0]  alloc_dest;

  // Buffer head to commit stage, also seen by the allocator
  logic              retire_valid;
  logic              retire_ready;
  logic [tag_w-1:0]  retire_tag;
  logic [reg_w-1:0]  retire_dest;
  logic [data_w-1:0] retire_data;

  rob_alloc u_alloc (
    .clk            (clk),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch_dest  (dispatch_dest),
    .dispatch_ready (dispatch_ready),
    .dispatch_tag   (dispatch_tag),
    .retire_valid   (retire_valid),
    .retire_ready   (retire_ready),
    .alloc_fire     (alloc_fire),
    .alloc_tag      (alloc_tag),
    .alloc_dest     (alloc_dest)
  );

  rob_buffer u_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_fire   (alloc_fire),
    .alloc_tag    (alloc_tag),
    .alloc_dest   (alloc_dest),
    .cmpl_valid   (cmpl_valid),
    .cmpl_tag     (cmpl_tag),
    .cmpl_data    (cmpl_data),
    .retire_ready (retire_ready),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag),
    .retire_dest  (retire_dest),
    .retire_data  (retire_data)
  );

  rob_commit u_commit (
    .clk          (clk),
    .rst_n        (rst_n),
    .retire_valid (retire_valid),
    .retire_tag   (retire_tag),
    .retire_dest  (retire_dest),
    .retire_data  (retire_data),
    .retire_ready (retire_ready),
    .commit_ready (commit_ready),
    .commit_valid (commit_valid),
    .commit_tag   (commit_tag),
    .commit_dest  (commit_dest),
    .commit_data  (commit_data)
  );

endmodule

// ==== logic/rob_commit.sv ====
// --------------------
// Commit skid stage
// Two registered entries, ready back to the buffer is registered
// --------------------

`timescale 1ns/100ps

module rob_commit (
  input  logic                       clk,
  input  logic                       rst_n,
  // Retired entries from the buffer
  input  logic                       retire_valid,
  input  logic [rob_pkg::tag_w-1:0]  retire_tag,
  input  logic [rob_pkg::reg_w-1:0]  retire_dest,
  input  logic [rob_pkg::data_w-1:0] retire_data,
  output logic                       retire_ready,
  // Commit port
  input  logic                       commit_ready,
  output logic                       commit_valid,
  output logic [rob_pkg::tag_w-1:0]  commit_tag,
  output logic [rob_pkg::reg_w-1:0]  commit_dest,
  output logic [rob_pkg::data_w-1:0] commit_data
);

  import rob_pkg::*;

  skid_state_e state_q;
  skid_state_e state_d;

  // Low only with both slots taken
  logic ready_q;

  // Front slot drives the commit port
  logic [tag_w-1:0]  out_tag_q;
  logic [reg_w-1:0]  out_dest_q;
  logic [data_w-1:0] out_data_q;
  // Back slot catches one more under stall
  logic [tag_w-1:0]  spare_tag_q;
  logic [reg_w-1:0]  spare_dest_q;
  logic [data_w-1:0] spare_data_q;

  logic in_fire;
  logic out_fire;
  logic load_out_in;
  logic load_out_spare;
  logic load_spare;

  assign in_fire  = retire_valid && ready_q;
  assign out_fire = commit_valid && commit_ready;

  // --------------------
  // Occupancy FSM
  // --------------------

  always_comb begin
    state_d        = state_q;
    load_out_in    = 1'b0;
    load_out_spare = 1'b0;
    load_spare     = 1'b0;
    case (state_q)
      skid_empty: begin
        if (in_fire) begin
          load_out_in = 1'b1;
          state_d     = skid_one;
        end
      end
      skid_one: begin
        // Pass-through keeps one entry
        if (in_fire && out_fire) begin
          load_out_in = 1'b1;
        end else if (in_fire) begin
          load_spare = 1'b1;
          state_d    = skid_two;
        end else if (out_fire) begin
          state_d = skid_empty;
        end
      end
      skid_two: begin
        // No input possible here, ready is low
        if (out_fire) begin
          load_out_spare = 1'b1;
          state_d        = skid_one;
        end
      end
      default: state_d = skid_empty;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= skid_empty;
      ready_q <= 1'b1;
    end else begin
      state_q <= state_d;
      ready_q <= (state_d != skid_two);
    end
  end

  // --------------------
  // Payload slots
  // --------------------

  always_ff @(posedge clk) begin
    if (load_out_in) begin
      out_tag_q  <= retire_tag;
      out_dest_q <= retire_dest;
      out_data_q <= retire_data;
    end else if (load_out_spare) begin
      out_tag_q  <= spare_tag_q;
      out_dest_q <= spare_dest_q;
      out_data_q <= spare_data_q;
    end
    if (load_spare) begin
      spare_tag_q  <= retire_tag;
      spare_dest_q <= retire_dest;
      spare_data_q <= retire_data;
    end
  end

  // All outputs straight from flops
  assign retire_ready = ready_q;
  assign commit_valid = (state_q != skid_empty);
  assign commit_tag   = out_tag_q;
  assign commit_dest  = out_dest_q;
  assign commit_data  = out_data_q;

endmodule

// ==== logic/rob_buffer.sv ====
// --------------------
// Reorder buffer entry storage
// Out-of-order completion writes, in-order retirement from the head
// --------------------

`timescale 1ns/100ps

module rob_buffer (
  input  logic                       clk,
  input  logic                       rst_n,
  // Allocation from the tail
  input  logic                       alloc_fire,
  input  logic [rob_pkg::tag_w-1:0]  alloc_tag,
  input  logic [rob_pkg::reg_w-1:0]  alloc_dest,
  // Tagged completion, always accepted
  input  logic                       cmpl_valid,
  input  logic [rob_pkg::tag_w-1:0]  cmpl_tag,
  input  logic [rob_pkg::data_w-1:0] cmpl_data,
  // Head entry towards the commit stage
  input  logic                       retire_ready,
  output logic                       retire_valid,
  output logic [rob_pkg::tag_w-1:0]  retire_tag,
  output logic [rob_pkg::reg_w-1:0]  retire_dest,
  output logic [rob_pkg::data_w-1:0] retire_data
);

  import rob_pkg::*;

  // --------------------
  // Storage
  // --------------------

  // Destination written at allocation
  logic [reg_w-1:0]  dest_mem [rob_depth];
  // Result written at completion
  logic [data_w-1:0] data_mem [rob_depth];

  // One done flag per entry
  logic [rob_depth-1:0] done_q;

  // Oldest entry in program order
  logic [tag_w-1:0] head_q;
  logic [tag_w-1:0] head_next;

  logic retire_fire;

  // --------------------
  // Retire handshake
  // --------------------

  // Head can leave once its result is back
  assign retire_valid = done_q[head_q];
  assign retire_fire  = retire_valid && retire_ready;

  // Head wraps like the tail
  always_comb begin
    if (head_q == tag_w'(rob_depth - 1)) begin
      head_next = '0;
    end else begin
      head_next = head_q + 1'b1;
    end
  end

  // --------------------
  // Payload writes
  // --------------------

  // Allocation and completion hit different fields
  always_ff @(posedge clk) begin
    if (alloc_fire) begin
      dest_mem[alloc_tag] <= alloc_dest;
    end
    if (cmpl_valid) begin
      data_mem[cmpl_tag] <= cmpl_data;
    end
  end

  // --------------------
  // Done flags and head pointer
  // --------------------

  // Retire, allocate and complete never share an entry:
  // retire needs done set, allocation only hits a free slot,
  // completion only hits an allocated, undone slot
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= '0;
      head_q <= '0;
    end else begin
      // Cleared on the way out
      // so a wrapped head never sees a stale flag
      if (retire_fire) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_next;
      end
      // Fresh entry starts undone
      if (alloc_fire) begin
        done_q[alloc_tag] <= 1'b0;
      end
      // Result arrived, in any order
      if (cmpl_valid) begin
        done_q[cmpl_tag] <= 1'b1;
      end
    end
  end

  // --------------------
  // Head entry outputs
  // --------------------

  assign retire_tag  = head_q;
  assign retire_dest = dest_mem[head_q];
  assign retire_data = data_mem[head_q];

endmodule

// ==== logic/rob_alloc.sv ====
// --------------------
// Reorder buffer allocator
// Hands out tail tags in program order and counts free entries
// --------------------

`timescale 1ns/100ps

module rob_alloc (
  input  logic                     clk,
  input  logic                     rst_n,
  // Dispatch side
  input  logic                     dispatch_valid,
  input  logic [rob_pkg::reg_w-1:0] dispatch_dest,
  output logic                     dispatch_ready,
  output logic [rob_pkg::tag_w-1:0] dispatch_tag,
  // Retire handshake returns one entry
  input  logic                     retire_valid,
  input  logic                     retire_ready,
  // Allocation request into the buffer
  output logic                     alloc_fire,
  output logic [rob_pkg::tag_w-1:0] alloc_tag,
  output logic [rob_pkg::reg_w-1:0] alloc_dest
);

  import rob_pkg::*;

  // Next tag to hand out
  logic [tag_w-1:0]  tail_q;
  // Entries not yet allocated
  logic [free_w-1:0] free_q;

  logic dispatch_fire;
  logic retire_fire;

  // --------------------
  // Handshakes
  // --------------------

  // Ready comes straight from the registered count
  assign dispatch_ready = (free_q != '0);
  assign dispatch_fire  = dispatch_valid && dispatch_ready;

  // Pop seen by the buffer, reused as free return
  assign retire_fire = retire_valid && retire_ready;

  // --------------------
  // Tail pointer and free count
  // --------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tail_q <= '0;
      free_q <= free_w'(rob_depth);
    end else begin
      // Tail wraps at the last entry
      if (dispatch_fire) begin
        if (tail_q == tag_w'(rob_depth - 1)) begin
          tail_q <= '0;
        end else begin
          tail_q <= tail_q + 1'b1;
        end
      end
      // Both events in one cycle cancel out
      case ({dispatch_fire, retire_fire})
        2'b10:   free_q <= free_q - 1'b1;
        2'b01:   free_q <= free_q + 1'b1;
        default: free_q <= free_q;
      endcase
    end
  end

  // --------------------
  // Outputs
  // --------------------

  // Tag offered to the dispatching instruction
  assign dispatch_tag = tail_q;

  // Accepted dispatch writes the tail entry
  assign alloc_fire = dispatch_fire;
  assign alloc_tag  = tail_q;
  assign alloc_dest = dispatch_dest;

endmodule

// ==== logic/rob_pkg.sv ====
// --------------------
// Reorder buffer shared definitions
// Buffer sizes, field widths and the commit stage state type
// --------------------

package rob_pkg;

  // --------------------
  // Buffer geometry
  // --------------------

  // Number of in-flight entries
  localparam int rob_depth = 8;

  // Tag addresses one entry
  localparam int tag_w = $clog2(rob_depth);

  // Free counter must reach rob_depth itself
  localparam int free_w = $clog2(rob_depth + 1);

  // --------------------
  // Payload widths
  // --------------------

  // Result value from the execution units
  localparam int data_w = 32;

  // Architectural destination register index
  localparam int reg_w = 5;

  // --------------------
  // Commit stage occupancy
  // --------------------

  // Entries held in the skid stage
  typedef enum logic [1:0] {
    skid_empty,
    skid_one,
    skid_two
  } skid_state_e;

endpackage
